/* if_stage.f */
rtl/if_pkg.sv
rtl/if_pc_sel.sv
rtl/if_prefetch.sv
rtl/if_id_pipe.sv
rtl/if_stage.sv
testbench/if_mem_model.sv
testbench/tb_if_stage.sv

/* rtl/if_id_pipe.sv */
// IF-ID pipeline register
// captures each accepted word, tracks valid and new flags for the ID stage
// and raises an alert when a sequential fetch breaks the plus-4 order
module if_id_pipe (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      item_valid_i,
  input  if_pkg::fetch_item_t       item_i,
  input  logic                      id_in_ready_i,
  input  logic                      pc_set_i,
  input  logic                      instr_valid_clear_i,
  output if_pkg::id_instr_t         id_instr_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [if_pkg::XLEN-1:0]   pc_if_o,
  output logic                      pc_mismatch_alert_o
);

  logic                      transfer;
  logic                      valid_d, valid_q;
  logic                      new_q;
  logic                      seq_d, seq_q;
  logic [if_pkg::XLEN-1:0]   pc_expected;
  if_pkg::id_instr_t         id_instr_q;

  ////////////////////////////////////////////////////////////////////////////
  // valid / new tracking
  ////////////////////////////////////////////////////////////////////////////

  assign transfer = item_valid_i & id_in_ready_i;

  // word accepted during a redirect is squashed
  // otherwise valid holds until ID clears it
  assign valid_d = (transfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  // sequence broken by any redirect, re-armed by the next accepted word
  assign seq_d = (seq_q | transfer) & ~pc_set_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      new_q      <= 1'b0;
      seq_q      <= 1'b0;
      id_instr_q <= '0;
    end else begin
      valid_q <= valid_d;
      new_q   <= transfer;
      seq_q   <= seq_d;
      if (transfer) begin
        id_instr_q <= '{rdata: item_i.rdata, pc: item_i.addr, err: item_i.err};
      end
    end
  end

  assign id_instr_o       = id_instr_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  ////////////////////////////////////////////////////////////////////////////
  // sequential pc check
  ////////////////////////////////////////////////////////////////////////////

  // address of the word on offer right now
  assign pc_if_o = item_i.addr;

  // only full words exist, so the successor is always plus 4
  assign pc_expected = id_instr_q.pc + 32'd4;

  assign pc_mismatch_alert_o = seq_q & item_valid_i & (pc_if_o != pc_expected);

endmodule

/* rtl/if_pc_sel.sv */
// next-pc selection
// builds the exception vector and picks the next fetch address on a redirect,
// also flags mtvec initialisation on boot
module if_pc_sel (
  input  logic                      pc_set_i,
  input  if_pkg::pc_sel_e           pc_mux_i,
  input  if_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic [4:0]                exc_cause_i,
  input  logic [if_pkg::XLEN-1:0]   boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]   branch_target_i,
  input  logic [if_pkg::XLEN-1:0]   csr_mepc_i,
  input  logic [if_pkg::XLEN-1:0]   csr_depc_i,
  input  logic [if_pkg::XLEN-1:0]   csr_mtvec_i,
  output logic [if_pkg::XLEN-1:0]   next_addr_o,
  output logic                      csr_mtvec_init_o
);

  logic [if_pkg::XLEN-1:0] exc_pc;

  // exception vector, mtvec base is 256-byte aligned
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[if_pkg::XLEN-1:8], 8'h00};
      // vectored mode, one word slot per interrupt id
      if_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[if_pkg::XLEN-1:8], 1'b0, exc_cause_i, 2'b00};
      if_pkg::EXC_PC_DBD:     exc_pc = if_pkg::DM_HALT_ADDR;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = if_pkg::DM_EXC_ADDR;
    endcase
  end

  // next fetch address
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_BOOT: next_addr_o = {boot_addr_i[if_pkg::XLEN-1:8], if_pkg::BOOT_OFFSET};
      if_pkg::PC_JUMP: next_addr_o = branch_target_i;
      // trap entry
      if_pkg::PC_EXC:  next_addr_o = exc_pc;
      // return from trap / debug
      if_pkg::PC_ERET: next_addr_o = csr_mepc_i;
      if_pkg::PC_DRET: next_addr_o = csr_depc_i;
      default:         next_addr_o = {boot_addr_i[if_pkg::XLEN-1:8], if_pkg::BOOT_OFFSET};
    endcase
  end

  // CSR file loads its mtvec reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

  // redirect checks, only while a redirect is requested
  always_comb begin
    if (pc_set_i) begin
      assert (pc_mux_i inside {if_pkg::PC_BOOT, if_pkg::PC_JUMP, if_pkg::PC_EXC,
                               if_pkg::PC_ERET, if_pkg::PC_DRET})
        else $error("illegal pc_mux_i on redirect");
      assert (boot_addr_i[7:0] == 8'h00)
        else $error("boot address not 256-byte aligned");
    end
  end

endmodule

/* rtl/if_pkg.sv */
// instruction fetch stage shared definitions
// widths, boot and debug entry points, selector enums and bus/pipe structs
package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and fixed addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;
  // boot fetch starts this far into the 256-byte aligned boot region
  localparam logic [7:0] BOOT_OFFSET = 8'h80;
  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR = 32'h1A11_0808;
  // prefetch buffer entries, also the cap on requests in flight
  localparam int unsigned FETCH_DEPTH = 2;
  // counter width able to hold 0 .. FETCH_DEPTH
  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // selector enums
  ////////////////////////////////////////////////////////////////////////////

  // next-pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // instruction bus request, addr held until gnt
  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } fetch_req_t;

  // instruction bus response, err only meaningful with rvalid
  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_rsp_t;

  // one word handed from prefetch buffer to IF-ID register
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic            err;
  } fetch_item_t;

  // IF-ID register contents
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] pc;
    logic            err;
  } id_instr_t;

endpackage

/* rtl/if_prefetch.sv */
// prefetch unit
// issues word fetches on the req/gnt/rvalid bus, counts requests in flight
// and buffers returned words, flushing everything stale on a redirect
module if_prefetch (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      branch_i,
  input  logic [if_pkg::XLEN-1:0]   branch_addr_i,
  input  if_pkg::fetch_rsp_t        fetch_rsp_i,
  input  logic                      item_ready_i,
  output if_pkg::fetch_req_t        fetch_req_o,
  output logic                      item_valid_o,
  output if_pkg::fetch_item_t       item_o,
  output logic                      busy_o
);

  logic                      started_q;
  logic [if_pkg::XLEN-1:0]   fetch_addr_q;
  logic [if_pkg::XLEN-1:0]   rsp_addr_q;
  logic [if_pkg::XLEN-1:0]   branch_aligned;
  logic [if_pkg::CNT_W-1:0]  outst_q, outst_d, outst_next;
  logic [if_pkg::CNT_W-1:0]  discard_q, discard_d, discard_next;
  logic [if_pkg::CNT_W-1:0]  buf_cnt_q, buf_cnt_d, buf_cnt_mid;
  logic [if_pkg::CNT_W:0]    inflight_sum;
  logic                      space;
  logic                      gnt_accept;
  logic                      rsp_keep, rsp_discard;
  logic                      push, pop;
  if_pkg::fetch_item_t       rsp_item;
  if_pkg::fetch_item_t       buf_q [if_pkg::FETCH_DEPTH];
  if_pkg::fetch_item_t       buf_d [if_pkg::FETCH_DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign branch_aligned = {branch_addr_i[if_pkg::XLEN-1:2], 2'b00};

  // in flight plus buffered words must leave room for every answer
  assign inflight_sum = {1'b0, outst_q} + {1'b0, discard_q} + {1'b0, buf_cnt_q};
  assign space        = inflight_sum < (if_pkg::CNT_W + 1)'(if_pkg::FETCH_DEPTH);

  assign fetch_req_o.req  = started_q & req_i & space;
  assign fetch_req_o.addr = fetch_addr_q;
  assign gnt_accept       = fetch_req_o.req & fetch_rsp_i.gnt;

  // answers come back in order, so stale ones always arrive first
  assign rsp_discard = fetch_rsp_i.rvalid & (discard_q != '0);
  assign rsp_keep    = fetch_rsp_i.rvalid & (discard_q == '0);

  always_comb begin
    outst_next   = outst_q + if_pkg::CNT_W'(gnt_accept) - if_pkg::CNT_W'(rsp_keep);
    discard_next = discard_q - if_pkg::CNT_W'(rsp_discard);
    if (branch_i) begin
      // everything still in flight now belongs to the old stream
      outst_d   = '0;
      discard_d = discard_next + outst_next;
    end else begin
      outst_d   = outst_next;
      discard_d = discard_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response buffer, entry 0 is the head
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_item = '{rdata: fetch_rsp_i.rdata, addr: rsp_addr_q, err: fetch_rsp_i.err};
  assign push     = rsp_keep & ~branch_i;
  assign pop      = item_valid_o & item_ready_i;

  always_comb begin
    buf_d       = buf_q;
    buf_cnt_mid = buf_cnt_q - if_pkg::CNT_W'(pop);
    if (pop) begin
      for (int i = 0; i < if_pkg::FETCH_DEPTH - 1; i++) begin
        buf_d[i] = buf_q[i+1];
      end
    end
    // new word lands behind whatever survives the pop
    for (int i = 0; i < if_pkg::FETCH_DEPTH; i++) begin
      if (push && (if_pkg::CNT_W'(i) == buf_cnt_mid)) begin
        buf_d[i] = rsp_item;
      end
    end
    buf_cnt_d = branch_i ? '0 : buf_cnt_mid + if_pkg::CNT_W'(push);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q    <= 1'b0;
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
      outst_q      <= '0;
      discard_q    <= '0;
      buf_cnt_q    <= '0;
      for (int i = 0; i < if_pkg::FETCH_DEPTH; i++) begin
        buf_q[i] <= '0;
      end
    end else begin
      // fetching begins with the first redirect seen while enabled
      if (branch_i && req_i) begin
        started_q <= 1'b1;
      end
      // a pending ungranted request is replaced by the redirect target
      if (branch_i) begin
        fetch_addr_q <= branch_aligned;
        rsp_addr_q   <= branch_aligned;
      end else begin
        if (gnt_accept) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (rsp_keep) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
      end
      outst_q   <= outst_d;
      discard_q <= discard_d;
      buf_cnt_q <= buf_cnt_d;
      buf_q     <= buf_d;
    end
  end

  assign item_valid_o = buf_cnt_q != '0;
  assign item_o       = buf_q[0];
  // stale requests still occupy the bus
  assign busy_o       = (outst_q != '0) | (discard_q != '0);

  // bus address clean and word aligned whenever a request is up
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_req_o.req |-> (!$isunknown(fetch_req_o.addr) && fetch_req_o.addr[1:0] == 2'b00));

  // every rvalid answers an earlier grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_rsp_i.rvalid |-> (outst_q != '0 || discard_q != '0));

endmodule

/* rtl/if_stage.sv */
// instruction fetch stage top
// next-pc select, prefetch unit and IF-ID register wired together
module if_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic [if_pkg::XLEN-1:0]   boot_addr_i,
  input  logic                      pc_set_i,
  input  if_pkg::pc_sel_e           pc_mux_i,
  input  if_pkg::exc_pc_sel_e       exc_pc_mux_i,
  input  logic [4:0]                exc_cause_i,
  input  logic [if_pkg::XLEN-1:0]   branch_target_i,
  input  logic [if_pkg::XLEN-1:0]   csr_mepc_i,
  input  logic [if_pkg::XLEN-1:0]   csr_depc_i,
  input  logic [if_pkg::XLEN-1:0]   csr_mtvec_i,
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  input  if_pkg::fetch_rsp_t        fetch_rsp_i,
  output if_pkg::fetch_req_t        fetch_req_o,
  output if_pkg::id_instr_t         id_instr_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [if_pkg::XLEN-1:0]   pc_if_o,
  output logic                      csr_mtvec_init_o,
  output logic                      pc_mismatch_alert_o,
  output logic                      if_busy_o
);

  logic [if_pkg::XLEN-1:0]   next_addr;
  logic                      item_valid;
  logic                      item_ready;
  if_pkg::fetch_item_t       item;

  // ID acceptance is the only back-pressure on the buffer
  assign item_ready = id_in_ready_i;

  if_pc_sel u_pc_sel (
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_cause_i     (exc_cause_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .next_addr_o     (next_addr),
    .csr_mtvec_init_o(csr_mtvec_init_o)
  );

  // every redirect restarts the prefetch stream at next_addr
  if_prefetch u_prefetch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .branch_i     (pc_set_i),
    .branch_addr_i(next_addr),
    .fetch_rsp_i  (fetch_rsp_i),
    .item_ready_i (item_ready),
    .fetch_req_o  (fetch_req_o),
    .item_valid_o (item_valid),
    .item_o       (item),
    .busy_o       (if_busy_o)
  );

  if_id_pipe u_id_pipe (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .item_valid_i       (item_valid),
    .item_i             (item),
    .id_in_ready_i      (id_in_ready_i),
    .pc_set_i           (pc_set_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .id_instr_o         (id_instr_o),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .pc_if_o            (pc_if_o),
    .pc_mismatch_alert_o(pc_mismatch_alert_o)
  );

endmodule

/* run.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_if_stage --Mdir obj_dir -o sim_if_stage -f if_stage.f

./obj_dir/sim_if_stage 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
  exit 0
fi
exit 1

/* testbench/if_mem_model.sv */
// instruction memory responder for the fetch bus
// grants after a random wait of 0 to 3 cycles, answers one cycle later
// with a pattern word, err raised inside the error window
module if_mem_model #(
  parameter logic [31:0] MEM_PATTERN = 32'h0000_0000,
  parameter logic [31:0] ERR_BASE    = 32'hFFFF_FFFF,
  parameter logic [31:0] ERR_LIMIT   = 32'hFFFF_FFFF
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  if_pkg::fetch_req_t  fetch_req_i,
  output if_pkg::fetch_rsp_t  fetch_rsp_o
);

  logic [1:0]  wait_q;
  logic        gnt;
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        err_q;

  // grant as soon as the wait for this request has run out
  assign gnt = fetch_req_i.req & (wait_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q   <= 2'd0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (gnt) begin
        // word depends on every address bit
        rdata_q <= fetch_req_i.addr ^ MEM_PATTERN;
        err_q   <= (fetch_req_i.addr >= ERR_BASE) && (fetch_req_i.addr <= ERR_LIMIT);
        wait_q  <= 2'($urandom_range(0, 3));
      end else if (fetch_req_i.req && (wait_q != 2'd0)) begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  assign fetch_rsp_o.gnt    = gnt;
  assign fetch_rsp_o.rvalid = rvalid_q;
  assign fetch_rsp_o.rdata  = rdata_q;
  // err only counts together with rvalid
  assign fetch_rsp_o.err    = err_q & rvalid_q;

endmodule

/* testbench/tb_if_stage.sv */
// testbench for the instruction fetch stage
// plays the ID stage and the CSR side, checks every delivered word
module tb_if_stage;

  localparam logic [31:0] MEM_PATTERN = 32'hA5C3_0F96;
  localparam logic [31:0] ERR_BASE    = 32'h0000_9000;
  localparam logic [31:0] ERR_LIMIT   = 32'h0000_90FF;
  localparam int unsigned SEED        = 75;
  localparam int RESET_CYCLES         = 16;
  // 16 boot + 24 back-pressure + 24 redirect + 20 trap + 16 bus error
  localparam int TOTAL_INSTR          = 100;
  localparam int CYCLES_PER_INSTR     = 200;

  logic                  clk_i, rst_ni, req_i, pc_set_i;
  logic [31:0]           boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  if_pkg::pc_sel_e       pc_mux_i;
  if_pkg::exc_pc_sel_e   exc_pc_mux_i;
  logic [4:0]            exc_cause_i;
  logic                  id_in_ready_i, instr_valid_clear_i;
  if_pkg::fetch_rsp_t    fetch_rsp;
  if_pkg::fetch_req_t    fetch_req;
  if_pkg::id_instr_t     id_instr_o;
  logic                  instr_valid_id_o, instr_new_id_o, csr_mtvec_init_o;
  logic                  pc_mismatch_alert_o, if_busy_o;
  logic [31:0]           pc_if_o;

  // ID model state
  logic [31:0] exp_pc, redir_pc, offered_pc;
  logic        redir_req, bp_on;
  int          accepted, cycle, redir_cycle;

  if_stage u_if_stage (
    .clk_i, .rst_ni, .req_i, .boot_addr_i, .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .exc_cause_i,
    .branch_target_i, .csr_mepc_i, .csr_depc_i, .csr_mtvec_i, .id_in_ready_i,
    .instr_valid_clear_i, .fetch_rsp_i(fetch_rsp), .fetch_req_o(fetch_req), .id_instr_o,
    .instr_valid_id_o, .instr_new_id_o, .pc_if_o, .csr_mtvec_init_o, .pc_mismatch_alert_o,
    .if_busy_o
  );

  if_mem_model #(.MEM_PATTERN(MEM_PATTERN), .ERR_BASE(ERR_BASE), .ERR_LIMIT(ERR_LIMIT)) u_mem (
    .clk_i, .rst_ni, .fetch_req_i(fetch_req), .fetch_rsp_o(fetch_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("MISMATCH %s got %h expected %h", name, got, exp);
    fail_run("value check failed");
  endtask

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_BASE) && (addr <= ERR_LIMIT);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // ID stage model, redirect pulses and per-cycle checks
  ////////////////////////////////////////////////////////////////////////////

  initial begin : id_stage_model
    int   hold_left;
    logic init_exp;
    hold_left           = 0;
    pc_set_i            = 1'b0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      cycle++;
      pc_set_i            = 1'b0;
      instr_valid_clear_i = 1'b0;
      if (rst_ni) begin
        if (hold_left > 0) begin
          assert (instr_valid_id_o) else fail_run("instr_valid_id_o fell before clear");
          hold_left--;
          instr_valid_clear_i = (hold_left == 0);
        end else if (instr_new_id_o && instr_valid_id_o) begin
          // the word just taken was on offer during the previous cycle
          assert (offered_pc == exp_pc)
            else flag_mismatch("pc_if_o", offered_pc, exp_pc);
          assert (id_instr_o.pc == exp_pc)
            else flag_mismatch("id_instr_o.pc", id_instr_o.pc, exp_pc);
          assert (id_instr_o.rdata == (exp_pc ^ MEM_PATTERN))
            else flag_mismatch("id_instr_o.rdata", id_instr_o.rdata, exp_pc ^ MEM_PATTERN);
          assert (id_instr_o.err == in_err_window(exp_pc))
            else flag_mismatch("id_instr_o.err", 32'(id_instr_o.err), 32'(in_err_window(exp_pc)));
          // first word of a new stream needs grant, rvalid and buffer
          if (accepted == 0) begin
            assert (cycle - redir_cycle >= 3)
              else fail_run("first instruction came too early");
          end
          exp_pc = exp_pc + 32'd4;
          accepted++;
          hold_left           = bp_on ? int'($urandom_range(0, 2)) : 0;
          instr_valid_clear_i = (hold_left == 0);
        end
        if (redir_req) begin
          pc_set_i    = 1'b1;
          exp_pc      = redir_pc;
          accepted    = 0;
          redir_cycle = cycle;
          redir_req   = 1'b0;
        end
        // no new word while the current one is still held
        id_in_ready_i = (hold_left == 0) && (!bp_on || ($urandom_range(0, 3) != 0));
        offered_pc    = pc_if_o;
      end
      #1;
      // mtvec init only with a boot redirect
      init_exp = pc_set_i && (pc_mux_i == if_pkg::PC_BOOT);
      assert (!pc_mismatch_alert_o) else fail_run("pc mismatch alert raised");
      assert (csr_mtvec_init_o == init_exp)
        else flag_mismatch("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(init_exp));
    end
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + CYCLES_PER_INSTR * TOTAL_INSTR) @(posedge clk_i);
    fail_run("timeout, the fetch stream stalled");
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic redirect_and_check(input if_pkg::pc_sel_e sel, input logic [31:0] first_pc,
                                    input int n);
    @(posedge clk_i);
    #1;
    pc_mux_i = sel;
    @(negedge clk_i);
    redir_pc  = first_pc;
    redir_req = 1'b1;
    wait (redir_req == 1'b0);
    while (accepted < n) @(posedge clk_i);
  endtask

  task automatic boot_test;
    redirect_and_check(if_pkg::PC_BOOT, {boot_addr_i[31:8], 8'h80}, 16);
  endtask

  task automatic backpressure_test;
    int start;
    start = accepted;
    @(negedge clk_i);
    bp_on = 1'b1;
    while (accepted < start + 24) @(posedge clk_i);
  endtask

  task automatic redirect_test;
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_5006;
    csr_mepc_i      = 32'h0000_6102;
    csr_depc_i      = 32'h0000_7208;
    redirect_and_check(if_pkg::PC_JUMP, 32'h0000_5004, 8);
    redirect_and_check(if_pkg::PC_ERET, 32'h0000_6100, 8);
    redirect_and_check(if_pkg::PC_DRET, 32'h0000_7208, 8);
  endtask

  task automatic trap_to(input if_pkg::exc_pc_sel_e sel, input logic [4:0] cause,
                         input logic [31:0] vector);
    @(posedge clk_i);
    #1;
    exc_pc_mux_i = sel;
    exc_cause_i  = cause;
    redirect_and_check(if_pkg::PC_EXC, vector, 4);
  endtask

  task automatic exc_vector_test;
    logic [31:0] base;
    @(posedge clk_i);
    #1;
    csr_mtvec_i = 32'h0000_4301;
    base        = csr_mtvec_i & 32'hFFFF_FF00;
    trap_to(if_pkg::EXC_PC_EXC, 5'd0, base);
    trap_to(if_pkg::EXC_PC_IRQ, 5'd5, base + 32'd5 * 32'd4);
    trap_to(if_pkg::EXC_PC_IRQ, 5'd17, base + 32'd17 * 32'd4);
    trap_to(if_pkg::EXC_PC_DBD, 5'd0, 32'h1A11_0800);
    trap_to(if_pkg::EXC_PC_DBG_EXC, 5'd0, 32'h1A11_0808);
  endtask

  task automatic bus_error_test;
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_9010;
    redirect_and_check(if_pkg::PC_JUMP, 32'h0000_9010, 8);
    @(posedge clk_i);
    #1;
    branch_target_i = 32'h0000_2000;
    redirect_and_check(if_pkg::PC_JUMP, 32'h0000_2000, 8);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    boot_addr_i     = 32'h0000_1000;
    pc_mux_i        = if_pkg::PC_BOOT;
    exc_pc_mux_i    = if_pkg::EXC_PC_EXC;
    exc_cause_i     = 5'd0;
    branch_target_i = '0;
    csr_mepc_i      = '0;
    csr_depc_i      = '0;
    csr_mtvec_i     = '0;
    redir_req = 1'b0;
    redir_pc  = '0;
    bp_on     = 1'b0;
    exp_pc    = '0;
    offered_pc = '0;
    accepted  = 0;
    cycle       = 0;
    redir_cycle = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    req_i  = 1'b1;
    @(posedge clk_i);
    #1;
    // nothing moves before the first redirect
    assert (!fetch_req.req && !if_busy_o && !instr_valid_id_o && !instr_new_id_o)
      else fail_run("stage not idle after reset");
    boot_test();
    backpressure_test();
    redirect_test();
    exc_vector_test();
    bus_error_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule
